/* all.f */
decode_pkg.sv
scoreboard_if.sv
regfile_scoreboard.sv
instr_classifier.sv
decode_control.sv
decode_stage.sv
tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - scoreboard_if.sv
  - regfile_scoreboard.sv
  - instr_classifier.sv
  - decode_control.sv
  - decode_stage.sv
  - target: simulation
    files:
      - tb_decode_stage.sv

/* tb_decode_stage.sv */
/*
 * Decode stage testbench
 * Directed and seeded random stimulus against a shadow register file,
 * scoreboard and jump flag model, with concurrent assertions as checkers
 */
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    localparam int STATUS_WIDTH = DEFAULT_STATUS_WIDTH;
    localparam int MAX_IN_FLIGHT = (1 << STATUS_WIDTH) - 1;
    localparam int DEPTH = 128;
    // Instructions sent by all tests and a per-instruction cycle bound
    localparam int NUM_INSTR = 60;
    localparam int CYCLES_PER_INSTR = 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_REGS
            + NUM_INSTR * CYCLES_PER_INSTR + 100;

    logic clk = 1'b0;
    logic arst_n;
    logic instruction_valid, instruction_ready;
    instr_word_t instruction_data;
    reg_value_t instruction_pc;
    jump_flag_t instruction_jump_flag;
    logic writeback_valid;
    reg_addr_t writeback_addr;
    reg_value_t writeback_value;
    logic jump_valid, jump_mispredicted;
    logic execute_valid;
    logic execute_ready = 1'b1;
    op_type_t execute_op_type;
    logic [2:0] execute_funct3;
    reg_addr_t execute_rd;
    reg_value_t execute_rs1_value, execute_rs2_value, execute_imm, execute_pc;
    jump_flag_t execute_jump_flag;
    logic retired, exit_flag;
    logic [EXIT_CODE_WIDTH-1:0] exit_code;

    int seed = 14;
    logic [DEPTH-1:0] ready_pattern;
    logic hold_enable = 1'b0;
    int ready_step = 0;

    // Shadow model
    reg_value_t shadow_regs [NUM_REGS];
    int pending [NUM_REGS];
    jump_flag_t shadow_flag = '0;
    logic model_jump_pending = 1'b0;
    logic model_exit = 1'b0;
    logic [EXIT_CODE_WIDTH-1:0] model_exit_code = '0;
    logic [6:0] sweep_cycles;
    int accept_count = 0;

    // Expected execute commands in issue order
    op_type_t exp_op [DEPTH];
    logic [2:0] exp_funct3 [DEPTH];
    reg_addr_t exp_rd [DEPTH];
    reg_value_t exp_rs1 [DEPTH], exp_rs2 [DEPTH], exp_imm [DEPTH], exp_pc [DEPTH];
    jump_flag_t exp_flag [DEPTH];
    int wr_ptr = 0;
    int rd_ptr = 0;

    // What the testbench knows about the instruction it is driving
    reg_addr_t drv_rs1, drv_rs2, drv_rd;
    logic drv_writes, drv_cf, drv_exit;
    op_type_t drv_op;
    logic [2:0] drv_funct3;
    reg_value_t drv_imm;
    reg_value_t next_pc = '0;
    jump_flag_t fetch_flag = '0;
    logic drv_flush, drv_blocked;

    assign drv_flush = model_exit || (instruction_jump_flag != shadow_flag);
    assign drv_blocked = (pending[drv_rs1] != 0) || (pending[drv_rs2] != 0)
            || (drv_writes && pending[drv_rd] >= MAX_IN_FLIGHT);

    decode_stage #(
        .STATUS_WIDTH(STATUS_WIDTH)
    ) uut (
        .clk, .arst_n,
        .instruction_valid, .instruction_ready, .instruction_data,
        .instruction_pc, .instruction_jump_flag,
        .writeback_valid, .writeback_addr, .writeback_value,
        .jump_valid, .jump_mispredicted,
        .execute_valid, .execute_ready, .execute_op_type, .execute_funct3,
        .execute_rd, .execute_rs1_value, .execute_rs2_value,
        .execute_imm, .execute_pc, .execute_jump_flag,
        .retired, .exit_flag, .exit_code
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (hold_enable) begin
            execute_ready = ready_pattern[ready_step % DEPTH];
            ready_step++;
        end else begin
            execute_ready = 1'b1;
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_cycles <= '0;
        end else if (sweep_cycles != '1) begin
            sweep_cycles <= sweep_cycles + 1'b1;
        end
    end

    // Model update from values seen at the clock edge
    always @(posedge clk) begin : model_update
        logic accepted;
        logic take;
        accepted = instruction_valid && instruction_ready;
        take = accepted && !drv_flush;
        if (arst_n) begin
            if (accepted) begin
                accept_count++;
            end
            if (take) begin
                exp_op[wr_ptr] = drv_op;
                exp_funct3[wr_ptr] = drv_funct3;
                exp_rd[wr_ptr] = drv_rd;
                exp_rs1[wr_ptr] = shadow_regs[drv_rs1];
                exp_rs2[wr_ptr] = shadow_regs[drv_rs2];
                exp_imm[wr_ptr] = drv_imm;
                exp_pc[wr_ptr] = instruction_pc;
                exp_flag[wr_ptr] = shadow_flag;
                wr_ptr++;
                if (drv_exit) begin
                    model_exit = 1'b1;
                    model_exit_code = shadow_regs[REG_A0][EXIT_CODE_WIDTH-1:0];
                end
            end
            if (execute_valid && execute_ready) begin
                rd_ptr++;
            end
            // Writebacks land after the reads of this edge
            if (writeback_valid) begin
                if (writeback_addr != '0) begin
                    shadow_regs[writeback_addr] = writeback_value;
                end
                pending[writeback_addr]--;
            end
            if (jump_valid) begin
                model_jump_pending = 1'b0;
                if (jump_mispredicted) begin
                    shadow_flag = shadow_flag + 1'b1;
                end
            end
            if (take && drv_writes) begin
                pending[drv_rd]++;
            end
            if (take && drv_cf) begin
                model_jump_pending = 1'b1;
            end
        end
    end

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    sweep_holds_input: assert property (
        @(posedge clk) disable iff (!arst_n)
        sweep_cycles < NUM_REGS |-> !instruction_ready
    ) else report_mismatch("instruction_ready high during the register sweep");

    sweep_length: assert property (
        @(posedge clk) disable iff (!arst_n)
        sweep_cycles == NUM_REGS |-> instruction_ready
    ) else report_mismatch("instruction_ready low after 32 sweep cycles");

    issue_rules: assert property (
        @(posedge clk) disable iff (!arst_n)
        instruction_valid && instruction_ready && !drv_flush
            |-> !drv_blocked && !model_jump_pending
    ) else report_mismatch("instruction issued while an operand or jump was pending");

    issue_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        instruction_valid && instruction_ready && !drv_flush |=> execute_valid
    ) else report_mismatch("issued instruction missing on the execute output next cycle");

    flush_accepted: assert property (
        @(posedge clk) disable iff (!arst_n)
        sweep_cycles >= NUM_REGS && instruction_valid && drv_flush |-> instruction_ready
    ) else report_mismatch("stale instruction was not consumed");

    retire_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        retired == (instruction_valid && instruction_ready && !drv_flush)
    ) else report_mismatch("retired does not match the issue");

    command_expected: assert property (
        @(posedge clk) disable iff (!arst_n)
        execute_valid |-> rd_ptr != wr_ptr
    ) else report_mismatch("execute_valid with no issued instruction");

    command_matches: assert property (
        @(posedge clk) disable iff (!arst_n)
        execute_valid && execute_ready |-> execute_op_type == exp_op[rd_ptr]
            && execute_funct3 == exp_funct3[rd_ptr] && execute_rd == exp_rd[rd_ptr]
            && execute_rs1_value == exp_rs1[rd_ptr] && execute_rs2_value == exp_rs2[rd_ptr]
            && execute_imm == exp_imm[rd_ptr] && execute_pc == exp_pc[rd_ptr]
            && execute_jump_flag == exp_flag[rd_ptr]
    ) else report_mismatch("execute command differs from the expected one");

    command_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        execute_valid && !execute_ready |=> execute_valid
            && $stable({execute_op_type, execute_funct3, execute_rd, execute_rs1_value,
                        execute_rs2_value, execute_imm, execute_pc, execute_jump_flag})
    ) else report_mismatch("execute payload changed while stalled");

    exit_status: assert property (
        @(posedge clk) disable iff (!arst_n)
        exit_flag == model_exit && exit_code == model_exit_code
    ) else report_mismatch("exit_flag or exit_code differs from the model");

    function automatic reg_addr_t random_reg();
        return reg_addr_t'($unsigned($random(seed)) % NUM_REGS);
    endfunction

    function automatic reg_addr_t random_dest();
        return reg_addr_t'(1 + $unsigned($random(seed)) % (NUM_REGS - 1));
    endfunction

    // Holds the instruction until the model counts its transfer
    task automatic send_instr(input logic [31:0] word);
        int start;
        start = accept_count;
        instruction_data = word;
        instruction_pc = next_pc;
        instruction_jump_flag = fetch_flag;
        instruction_valid = 1'b1;
        next_pc = next_pc + 4;
        while (accept_count == start) begin
            @(negedge clk);
        end
        instruction_valid = 1'b0;
    endtask

    task automatic send_add(input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
        drv_rs1 = rs1;
        drv_rs2 = rs2;
        drv_rd = rd;
        drv_writes = (rd != '0);
        drv_cf = 1'b0;
        drv_exit = 1'b0;
        drv_op = ALU;
        drv_funct3 = 3'b000;
        drv_imm = '0;
        send_instr({7'b0, rs2, rs1, 3'b000, rd, OPCODE_OP});
    endtask

    // BEQ with offset -8
    task automatic send_branch(input reg_addr_t rs1, input reg_addr_t rs2);
        drv_rs1 = rs1;
        drv_rs2 = rs2;
        drv_rd = '0;
        drv_writes = 1'b0;
        drv_cf = 1'b1;
        drv_exit = 1'b0;
        drv_op = BRANCH;
        drv_funct3 = 3'b000;
        drv_imm = 32'hffff_fff8;
        send_instr({1'b1, 6'h3f, rs2, rs1, 3'b000, 4'b1100, 1'b1, OPCODE_BRANCH});
    endtask

    task automatic send_ebreak();
        drv_rs1 = REG_A0;
        drv_rs2 = '0;
        drv_rd = '0;
        drv_writes = 1'b0;
        drv_cf = 1'b0;
        drv_exit = 1'b1;
        drv_op = HALT;
        drv_funct3 = 3'b000;
        drv_imm = 32'd1;
        send_instr(32'h0010_0073);
    endtask

    task automatic write_back(input reg_addr_t addr, input reg_value_t value);
        writeback_valid = 1'b1;
        writeback_addr = addr;
        writeback_value = value;
        @(negedge clk);
        writeback_valid = 1'b0;
    endtask

    task automatic pulse_jump(input logic mispredicted);
        jump_valid = 1'b1;
        jump_mispredicted = mispredicted;
        @(negedge clk);
        jump_valid = 1'b0;
        jump_mispredicted = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_value_t value);
        send_add(addr, '0, '0);
        write_back(addr, value);
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("Timeout: the tests did not finish in time");
    end

    initial begin : stimulus
        int i;
        arst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction_data = '0;
        instruction_pc = '0;
        instruction_jump_flag = '0;
        writeback_valid = 1'b0;
        writeback_addr = '0;
        writeback_value = '0;
        jump_valid = 1'b0;
        jump_mispredicted = 1'b0;
        for (i = 0; i < NUM_REGS; i++) begin
            shadow_regs[i] = '0;
            pending[i] = 0;
        end
        for (i = 0; i < DEPTH / 32; i++) begin
            ready_pattern[i*32 +: 32] = $random(seed);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        // First ADD waits out the sweep and reads zeros
        send_add('0, random_reg(), random_reg());

        for (i = 0; i < 8; i++) begin
            write_reg(random_dest(), $random(seed));
        end
        for (i = 0; i < 8; i++) begin
            send_add('0, random_reg(), random_reg());
        end

        // Reader of x7 must wait for its writeback
        send_add(5'd7, '0, '0);
        fork
            send_add('0, 5'd7, 5'd3);
            begin
                repeat (4) @(negedge clk);
                write_back(5'd7, $random(seed));
            end
        join

        // Correctly predicted branch, then a mispredicted one
        send_branch(random_reg(), random_reg());
        fork
            send_add('0, random_reg(), random_reg());
            begin
                repeat (5) @(negedge clk);
                pulse_jump(1'b0);
            end
        join
        send_branch(random_reg(), random_reg());
        fork
            send_add('0, random_reg(), random_reg());
            begin
                repeat (5) @(negedge clk);
                pulse_jump(1'b1);
            end
        join
        for (i = 0; i < 3; i++) begin
            send_add('0, random_reg(), random_reg());
        end
        fetch_flag = fetch_flag + 1'b1;
        for (i = 0; i < 4; i++) begin
            send_add('0, random_reg(), random_reg());
        end

        hold_enable = 1'b1;
        for (i = 0; i < 24; i++) begin
            send_add('0, random_reg(), random_reg());
        end
        hold_enable = 1'b0;

        write_reg(REG_A0, $random(seed));
        send_ebreak();
        for (i = 0; i < 4; i++) begin
            send_add('0, random_reg(), random_reg());
        end
        repeat (4) @(negedge clk);

        if (rd_ptr != wr_ptr) begin
            report_failure("Issued instructions never reached the execute output");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* decode_stage.sv */
/*
 * RV32I decode stage
 * Joins the classifier, the decode control and the register file
 * scoreboard behind plain instruction, writeback, jump and execute ports
 */
module decode_stage #(
    parameter int STATUS_WIDTH = decode_pkg::DEFAULT_STATUS_WIDTH
) (
    input logic clk,
    input logic arst_n,

    input logic instruction_valid,
    output logic instruction_ready,
    input decode_pkg::instr_word_t instruction_data,
    input decode_pkg::reg_value_t instruction_pc,
    input decode_pkg::jump_flag_t instruction_jump_flag,

    input logic writeback_valid,
    input decode_pkg::reg_addr_t writeback_addr,
    input decode_pkg::reg_value_t writeback_value,

    input logic jump_valid,
    input logic jump_mispredicted,

    output logic execute_valid,
    input logic execute_ready,
    output decode_pkg::op_type_t execute_op_type,
    output logic [2:0] execute_funct3,
    output decode_pkg::reg_addr_t execute_rd,
    output decode_pkg::reg_value_t execute_rs1_value,
    output decode_pkg::reg_value_t execute_rs2_value,
    output decode_pkg::reg_value_t execute_imm,
    output decode_pkg::reg_value_t execute_pc,
    output decode_pkg::jump_flag_t execute_jump_flag,

    output logic retired,
    output logic exit_flag,
    output logic [decode_pkg::EXIT_CODE_WIDTH-1:0] exit_code
);
    import decode_pkg::*;

    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    reg_value_t imm;
    op_type_t op_type;
    logic [2:0] funct3;
    logic writes_rd, is_control_flow, is_exit;

    scoreboard_if sb ();

    instr_classifier classifier_inst (
        .instruction_data,
        .rs1_addr, .rs2_addr, .rd_addr,
        .imm, .op_type, .funct3,
        .writes_rd, .is_control_flow, .is_exit
    );

    decode_control control_inst (
        .clk, .arst_n,
        .sb(sb.control),
        .instruction_valid, .instruction_ready,
        .instruction_pc, .instruction_jump_flag,
        .rs1_addr, .rs2_addr, .rd_addr,
        .op_type, .funct3, .imm,
        .is_control_flow, .is_exit, .writes_rd,
        .jump_valid, .jump_mispredicted,
        .execute_valid, .execute_ready,
        .execute_op_type, .execute_funct3, .execute_rd,
        .execute_rs1_value, .execute_rs2_value,
        .execute_imm, .execute_pc, .execute_jump_flag,
        .retired, .exit_flag, .exit_code
    );

    regfile_scoreboard #(
        .STATUS_WIDTH(STATUS_WIDTH)
    ) scoreboard_inst (
        .clk, .arst_n,
        .sb(sb.scoreboard),
        .writeback_valid, .writeback_addr, .writeback_value
    );

endmodule

/* decode_control.sv */
/*
 * Decode control
 * Clear/normal/exit FSM, jump flag tracking, issue, stall and flush
 * decisions, the exit latch and the registered execute command
 */
module decode_control (
    input logic clk,
    input logic arst_n,

    scoreboard_if.control sb,

    input logic instruction_valid,
    output logic instruction_ready,
    input decode_pkg::reg_value_t instruction_pc,
    input decode_pkg::jump_flag_t instruction_jump_flag,

    input decode_pkg::reg_addr_t rs1_addr,
    input decode_pkg::reg_addr_t rs2_addr,
    input decode_pkg::reg_addr_t rd_addr,
    input decode_pkg::op_type_t op_type,
    input logic [2:0] funct3,
    input decode_pkg::reg_value_t imm,
    input logic is_control_flow,
    input logic is_exit,
    input logic writes_rd,

    input logic jump_valid,
    input logic jump_mispredicted,

    output logic execute_valid,
    input logic execute_ready,
    output decode_pkg::op_type_t execute_op_type,
    output logic [2:0] execute_funct3,
    output decode_pkg::reg_addr_t execute_rd,
    output decode_pkg::reg_value_t execute_rs1_value,
    output decode_pkg::reg_value_t execute_rs2_value,
    output decode_pkg::reg_value_t execute_imm,
    output decode_pkg::reg_value_t execute_pc,
    output decode_pkg::jump_flag_t execute_jump_flag,

    output logic retired,
    output logic exit_flag,
    output logic [decode_pkg::EXIT_CODE_WIDTH-1:0] exit_code
);
    import decode_pkg::*;

    localparam int SWEEP_WIDTH = $clog2(NUM_REGS);
    localparam logic [SWEEP_WIDTH-1:0] SWEEP_LAST = SWEEP_WIDTH'(NUM_REGS - 1);

    decode_state_t state, next_state;
    logic [SWEEP_WIDTH-1:0] sweep_count;
    jump_flag_t jump_flag;
    logic jump_pending;

    reg_addr_t dest_addr;
    logic flag_match, output_free, operands_ready;
    logic flush, issue;

    // Non-writing instructions look up x0, which is always free
    assign dest_addr = writes_rd ? rd_addr : '0;

    assign sb.rs1_addr = rs1_addr;
    assign sb.rs2_addr = rs2_addr;
    assign sb.rd_addr = dest_addr;
    assign sb.sweep_active = (state == CLEAR);
    assign sb.issue_rd = issue && writes_rd;

    assign flag_match = (instruction_jump_flag == jump_flag);
    assign output_free = !execute_valid || execute_ready;
    assign operands_ready = sb.rs1_ready && sb.rs2_ready && sb.rd_free;

    always_comb begin
        instruction_ready = 1'b0;
        flush = 1'b0;
        case (state)
        NORMAL: begin
            if (!flag_match) begin
                // Wrong-path instruction, drop it
                instruction_ready = 1'b1;
                flush = 1'b1;
            end else begin
                instruction_ready = output_free && operands_ready && !jump_pending;
            end
        end
        EXIT: begin
            instruction_ready = 1'b1;
            flush = 1'b1;
        end
        default: begin
            instruction_ready = 1'b0;
        end
        endcase
    end

    assign issue = instruction_valid && instruction_ready && !flush;
    assign retired = issue;
    assign exit_flag = (state == EXIT);

    always_comb begin
        case (state)
        CLEAR: next_state = (sweep_count == SWEEP_LAST) ? NORMAL : CLEAR;
        NORMAL: next_state = (issue && is_exit) ? EXIT : NORMAL;
        EXIT: next_state = EXIT;
        default: next_state = CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CLEAR;
            sweep_count <= '0;
        end else begin
            state <= next_state;
            if (state == CLEAR) begin
                sweep_count <= sweep_count + 1'b1;
            end
        end
    end

    // New flag takes effect the cycle after a mispredicted jump
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            jump_flag <= '0;
            jump_pending <= 1'b0;
        end else begin
            if (jump_valid) begin
                jump_pending <= 1'b0;
                if (jump_mispredicted) begin
                    jump_flag <= jump_flag + 1'b1;
                end
            end
            if (issue && is_control_flow) begin
                jump_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exit_code <= '0;
        end else if (issue && is_exit) begin
            exit_code <= sb.rs1_value[EXIT_CODE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            execute_valid <= 1'b0;
        end else if (issue) begin
            execute_valid <= 1'b1;
        end else if (execute_ready) begin
            execute_valid <= 1'b0;
        end
    end

    // Payload only loads on issue, so it holds while stalled
    always_ff @(posedge clk) begin
        if (issue) begin
            execute_op_type <= op_type;
            execute_funct3 <= funct3;
            execute_rd <= dest_addr;
            execute_rs1_value <= sb.rs1_value;
            execute_rs2_value <= sb.rs2_value;
            execute_imm <= imm;
            execute_pc <= instruction_pc;
            execute_jump_flag <= instruction_jump_flag;
        end
    end

endmodule

/* instr_classifier.sv */
/*
 * Instruction classifier
 * Splits an RV32I word into register fields and immediate, and sorts the
 * opcode into an operation type, control flow and exit
 */
module instr_classifier (
    input decode_pkg::instr_word_t instruction_data,

    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr,
    output decode_pkg::reg_addr_t rd_addr,
    output decode_pkg::reg_value_t imm,
    output decode_pkg::op_type_t op_type,
    output logic [2:0] funct3,
    output logic writes_rd,
    output logic is_control_flow,
    output logic is_exit
);
    import decode_pkg::*;

    logic [31:0] word;
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [11:0] imm12;
    reg_addr_t rd_field;
    reg_value_t imm_i, imm_s, imm_b, imm_u, imm_j;
    logic is_ebreak;
    logic known_opcode;
    logic uses_rs1, uses_rs2, has_rd;

    assign word = instruction_data;
    assign opcode = instruction_data.r_view.opcode;
    assign funct7 = instruction_data.r_view.funct7;
    assign rd_field = instruction_data.r_view.rd;
    assign funct3 = instruction_data.r_view.funct3;
    assign imm12 = instruction_data.i_view.imm12;

    // Immediates per format, sign bit is always word[31]
    assign imm_i = {{20{imm12[11]}}, imm12};
    assign imm_s = {{20{funct7[6]}}, funct7, rd_field};
    assign imm_b = {{20{funct7[6]}}, rd_field[0], funct7[5:0], rd_field[4:1], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    assign is_ebreak = (opcode == OPCODE_SYSTEM) && (funct3 == 3'b000)
            && (imm12 == FUNCT12_EBREAK);

    always_comb begin
        known_opcode = 1'b1;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        has_rd = 1'b0;
        op_type = ALU;
        imm = '0;
        case (opcode)
        OPCODE_OP: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            has_rd = 1'b1;
        end
        OPCODE_OP_IMM, OPCODE_LOAD: begin
            uses_rs1 = 1'b1;
            has_rd = 1'b1;
            imm = imm_i;
            op_type = (opcode == OPCODE_LOAD) ? LOAD : ALU;
        end
        OPCODE_STORE: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            imm = imm_s;
            op_type = STORE;
        end
        OPCODE_BRANCH: begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            imm = imm_b;
            op_type = BRANCH;
        end
        OPCODE_JAL: begin
            has_rd = 1'b1;
            imm = imm_j;
            op_type = JUMP;
        end
        OPCODE_JALR: begin
            uses_rs1 = 1'b1;
            has_rd = 1'b1;
            imm = imm_i;
            op_type = JUMP;
        end
        OPCODE_LUI, OPCODE_AUIPC: begin
            has_rd = 1'b1;
            imm = imm_u;
        end
        OPCODE_SYSTEM: begin
            // Other system instructions pass through as a no-op ALU command
            imm = imm_i;
            op_type = is_ebreak ? HALT : ALU;
        end
        default: begin
            known_opcode = 1'b0;
            op_type = HALT;
        end
        endcase
    end

    // EBREAK reads a0 for the exit code
    assign rs1_addr = is_ebreak ? REG_A0 : (uses_rs1 ? instruction_data.r_view.rs1 : '0);
    assign rs2_addr = uses_rs2 ? instruction_data.r_view.rs2 : '0;
    assign rd_addr = rd_field;

    assign writes_rd = has_rd && (rd_field != '0);
    assign is_control_flow = (op_type == BRANCH) || (op_type == JUMP);
    assign is_exit = is_ebreak || !known_opcode;

endmodule

/* regfile_scoreboard.sv */
/*
 * Register file and scoreboard
 * 32 registers with combinational reads, plus front (issued writers) and
 * rear (writebacks) counters per register that give operand readiness
 */
module regfile_scoreboard #(
    parameter int STATUS_WIDTH = decode_pkg::DEFAULT_STATUS_WIDTH
) (
    input logic clk,
    input logic arst_n,

    scoreboard_if.scoreboard sb,

    input logic writeback_valid,
    input decode_pkg::reg_addr_t writeback_addr,
    input decode_pkg::reg_value_t writeback_value
);
    import decode_pkg::*;

    // Largest number of writers that can be in flight for one register
    localparam logic [STATUS_WIDTH-1:0] STATUS_MAX = '1;

    reg_value_t regs [NUM_REGS];
    logic [STATUS_WIDTH-1:0] front_status [NUM_REGS];
    logic [STATUS_WIDTH-1:0] rear_status [NUM_REGS];

    reg_addr_t sweep_index;
    logic [STATUS_WIDTH-1:0] rd_distance;

    // Sweep walks 0..31 once and wraps back to 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_index <= '0;
        end else if (sb.sweep_active) begin
            sweep_index <= sweep_index + 1'b1;
        end
    end

    // x0 is cleared by the sweep and never written again
    always_ff @(posedge clk) begin
        if (sb.sweep_active) begin
            regs[sweep_index] <= '0;
        end else if (writeback_valid && writeback_addr != '0) begin
            regs[writeback_addr] <= writeback_value;
        end
    end

    always_ff @(posedge clk) begin
        if (sb.sweep_active) begin
            front_status[sweep_index] <= '0;
        end else if (sb.issue_rd) begin
            front_status[sb.rd_addr] <= front_status[sb.rd_addr] + 1'b1;
        end
    end

    // Writebacks to x0 still count here
    always_ff @(posedge clk) begin
        if (sb.sweep_active) begin
            rear_status[sweep_index] <= '0;
        end else if (writeback_valid) begin
            rear_status[writeback_addr] <= rear_status[writeback_addr] + 1'b1;
        end
    end

    // No bypass: a writeback is visible from the next cycle
    assign sb.rs1_value = regs[sb.rs1_addr];
    assign sb.rs2_value = regs[sb.rs2_addr];

    // x0 never waits, whatever its counters say
    assign sb.rs1_ready = (sb.rs1_addr == '0)
            || (front_status[sb.rs1_addr] == rear_status[sb.rs1_addr]);
    assign sb.rs2_ready = (sb.rs2_addr == '0)
            || (front_status[sb.rs2_addr] == rear_status[sb.rs2_addr]);

    assign rd_distance = front_status[sb.rd_addr] - rear_status[sb.rd_addr];
    assign sb.rd_free = (sb.rd_addr == '0) || (rd_distance != STATUS_MAX);

    // Every writeback must match a writer issued earlier by the control
    writeback_has_writer: assert property (
        @(posedge clk) disable iff (!arst_n)
        writeback_valid && !sb.sweep_active && writeback_addr != '0
            |-> front_status[writeback_addr] != rear_status[writeback_addr]
    ) else $error("writeback to x%0d with no outstanding writer", writeback_addr);

    // A new writer never targets x0 and never overflows the front counter
    issue_has_room: assert property (
        @(posedge clk) disable iff (!arst_n)
        sb.issue_rd |-> sb.rd_addr != '0 && rd_distance != STATUS_MAX
    ) else $error("issue to x%0d with no free status slot", sb.rd_addr);

endmodule

/* scoreboard_if.sv */
/*
 * Scoreboard link
 * Operand and destination lookups from the decode control into the
 * register file, with values and readiness coming back
 */
interface scoreboard_if;
    import decode_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic issue_rd;
    logic sweep_active;

    reg_value_t rs1_value;
    reg_value_t rs2_value;
    logic rs1_ready;
    logic rs2_ready;
    logic rd_free;

    modport control (
        output rs1_addr, rs2_addr, rd_addr, issue_rd, sweep_active,
        input rs1_value, rs2_value, rs1_ready, rs2_ready, rd_free
    );

    modport scoreboard (
        input rs1_addr, rs2_addr, rd_addr, issue_rd, sweep_active,
        output rs1_value, rs2_value, rs1_ready, rs2_ready, rd_free
    );

endinterface

/* decode_pkg.sv */
/*
 * Decode stage shared definitions
 * Register and flag widths, RV32I opcodes, the instruction word views,
 * operation types and the decode FSM states
 */
package decode_pkg;

    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_VALUE_WIDTH = 32;
    localparam int JUMP_FLAG_WIDTH = 2;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [REG_VALUE_WIDTH-1:0] reg_value_t;
    typedef logic [JUMP_FLAG_WIDTH-1:0] jump_flag_t;

    // Length of the register clear sweep after reset
    localparam int NUM_REGS = 32;

    localparam int EXIT_CODE_WIDTH = 8;
    localparam reg_addr_t REG_A0 = 5'd10;

    // Default width of the per-register front and rear counters
    localparam int DEFAULT_STATUS_WIDTH = 2;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    localparam logic [11:0] FUNCT12_EBREAK = 12'h001;

    // Same 32-bit word seen as R-type and as I-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t rs2;
            reg_addr_t rs1;
            logic [2:0] funct3;
            reg_addr_t rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t rs1;
            logic [2:0] funct3;
            reg_addr_t rd;
            logic [6:0] opcode;
        } i_view;
    } instr_word_t;

    typedef enum logic [2:0] {
        ALU,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        HALT
    } op_type_t;

    typedef enum logic [1:0] {
        CLEAR,
        NORMAL,
        EXIT
    } decode_state_t;

endpackage
